//--- hw/apb_timer_unit.sv
// Compare timer on APB, counts clk_i cycles or ref-clock rises and pulses an interrupt on match
`include "soc_periph_config.svh"
`timescale 1ns/1ps

module apb_timer_unit
  import soc_periph_bus_pkg::*;
  import soc_periph_irq_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  apb_req_t req_i,
  output apb_rsp_t rsp_o,
  input  logic     ref_tick_i,
  output logic     irq_o
);

  addr_t    offset;
  logic     access;
  logic     wr_en;
  logic     wr_count;
  logic     err;
  logic     tick;
  logic     match;
  logic     cfg_en_q;
  logic     cfg_src_q;
  tmr_cnt_t count_q;
  tmr_cnt_t cmp_q;
  logic     irq_q;

  assign offset   = req_i.paddr & addr_t'(`SOC_PERIPH_REGION_SIZE - 1);
  assign access   = req_i.psel & req_i.penable;
  assign wr_en    = access & req_i.pwrite;
  assign wr_count = wr_en && offset == `SOC_PERIPH_TMR_COUNT_OFS;

  // Source 1 counts reference rises, source 0 every clock
  assign tick  = cfg_en_q & (cfg_src_q ? ref_tick_i : 1'b1);
  assign match = count_q == cmp_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_en_q  <= 1'b0;
      cfg_src_q <= 1'b0;
      count_q   <= '0;
      cmp_q     <= '0;
      irq_q     <= 1'b0;
    end else begin
      if (wr_en && offset == `SOC_PERIPH_TMR_CFG_OFS) begin
        cfg_en_q  <= req_i.pwdata[0];
        cfg_src_q <= req_i.pwdata[1];
      end
      if (wr_en && offset == `SOC_PERIPH_TMR_CMP_OFS) begin
        cmp_q <= req_i.pwdata;
      end
      // Bus write to COUNT beats the tick
      if (wr_count) begin
        count_q <= req_i.pwdata;
      end else if (tick) begin
        count_q <= match ? '0 : count_q + 1'b1;
      end
      irq_q <= tick & match & ~wr_count;
    end
  end

  always_comb begin
    rsp_o.prdata = '0;
    err          = 1'b0;
    case (offset)
      `SOC_PERIPH_TMR_CFG_OFS:   rsp_o.prdata = {30'b0, cfg_src_q, cfg_en_q};
      `SOC_PERIPH_TMR_COUNT_OFS: rsp_o.prdata = count_q;
      `SOC_PERIPH_TMR_CMP_OFS:   rsp_o.prdata = cmp_q;
      default:                   err = 1'b1;
    endcase
  end

  assign rsp_o.pready  = 1'b1;
  assign rsp_o.pslverr = access & err;
  assign irq_o         = irq_q;

  // With a nonzero compare the interrupt is a pulse, never a level
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (irq_o && cmp_q != '0) |=> !irq_o)
    else $error("timer interrupt held for two cycles");

endmodule

//--- hw/periph_apb_demux.sv
// Routes the single APB port to the SoC control and timer slaves, errors on unmapped addresses
`include "soc_periph_config.svh"
`timescale 1ns/1ps

module periph_apb_demux
  import soc_periph_bus_pkg::*;
(
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  output apb_req_t ctrl_req_o,
  output apb_req_t tmr_req_o,
  input  apb_rsp_t ctrl_rsp_i,
  input  apb_rsp_t tmr_rsp_i
);

  logic hit_ctrl;
  logic hit_tmr;

  // Address windows
  assign hit_ctrl = (apb_req_i.paddr >= `SOC_PERIPH_SOC_CTRL_BASE) &&
                    (apb_req_i.paddr <  `SOC_PERIPH_SOC_CTRL_BASE + `SOC_PERIPH_REGION_SIZE);
  assign hit_tmr  = (apb_req_i.paddr >= `SOC_PERIPH_TIMER_BASE) &&
                    (apb_req_i.paddr <  `SOC_PERIPH_TIMER_BASE + `SOC_PERIPH_REGION_SIZE);

  // Every slave sees the bus, only the hit one is selected
  always_comb begin
    ctrl_req_o      = apb_req_i;
    ctrl_req_o.psel = apb_req_i.psel & hit_ctrl;
    tmr_req_o       = apb_req_i;
    tmr_req_o.psel  = apb_req_i.psel & hit_tmr;
  end

  always_comb begin
    if (hit_ctrl) begin
      apb_rsp_o = ctrl_rsp_i;
    end else if (hit_tmr) begin
      apb_rsp_o = tmr_rsp_i;
    end else begin
      // Nobody home, complete at once with an error
      apb_rsp_o.prdata  = '0;
      apb_rsp_o.pready  = 1'b1;
      apb_rsp_o.pslverr = 1'b1;
    end
  end

  // The regions in the address map must not overlap
  always_comb begin
    assert (!(ctrl_req_o.psel && tmr_req_o.psel))
      else $error("APB demux selects both slaves at 0x%08h", apb_req_i.paddr);
  end

endmodule

//--- hw/ref_clk_edge_sync.sv
// Brings the slow reference clock into clk_i and turns its edges into single-cycle pulses
`timescale 1ns/1ps

module ref_clk_edge_sync (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic slow_clk_i,
  output logic rise_o,
  output logic fall_o
);

  logic [1:0] sync_q;
  logic       hist_q;

  // Two synchronizer stages, then one sample of history
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q <= '0;
      hist_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], slow_clk_i};
      hist_q <= sync_q[1];
    end
  end

  assign rise_o = sync_q[1] & ~hist_q;
  assign fall_o = ~sync_q[1] & hist_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni) !(rise_o && fall_o))
    else $error("ref clock rise and fall pulses overlap");

endmodule

//--- hw/soc_ctrl_regs.sv
// SoC control register file: boot address, fetch enable, JTAG, boot select and cluster reset
`include "soc_periph_config.svh"
`timescale 1ns/1ps

module soc_ctrl_regs
  import soc_periph_bus_pkg::*;
  import soc_periph_irq_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  apb_req_t  req_i,
  output apb_rsp_t  rsp_o,
  input  jtag_reg_t jtag_i,
  output jtag_reg_t jtag_o,
  input  bootsel_t  bootsel_i,
  input  logic      fetch_en_valid_i,
  input  logic      fetch_en_i,
  output addr_t     bootaddr_o,
  output logic      fetch_en_o,
  output logic      cluster_rstn_req_o
);

  addr_t     offset;
  logic      access;
  logic      wr_en;
  logic      err;
  addr_t     bootaddr_q;
  logic      fetch_en_q;
  jtag_reg_t jtag_out_q;
  logic      cluster_q;

  assign offset = req_i.paddr & addr_t'(`SOC_PERIPH_REGION_SIZE - 1);
  assign access = req_i.psel & req_i.penable;
  assign wr_en  = access & req_i.pwrite;

  //////////////////////////////////////////////////
  // Writable registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bootaddr_q <= `SOC_PERIPH_BOOTADDR_RST;
      fetch_en_q <= 1'b0;
      jtag_out_q <= '0;
      cluster_q  <= 1'b0;
    end else begin
      if (wr_en && offset == `SOC_PERIPH_CTRL_BOOTADDR_OFS) begin
        bootaddr_q <= req_i.pwdata;
      end
      // Pad-side fetch enable has priority over the bus
      if (fetch_en_valid_i) begin
        fetch_en_q <= fetch_en_i;
      end else if (wr_en && offset == `SOC_PERIPH_CTRL_FETCH_EN_OFS) begin
        fetch_en_q <= req_i.pwdata[0];
      end
      if (wr_en && offset == `SOC_PERIPH_CTRL_JTAG_OFS) begin
        jtag_out_q <= jtag_reg_t'(req_i.pwdata[7:0]);
      end
      if (wr_en && offset == `SOC_PERIPH_CTRL_CLUSTER_OFS) begin
        cluster_q <= req_i.pwdata[0];
      end
    end
  end

  //////////////////////////////////////////////////
  // Read data and error decode
  //////////////////////////////////////////////////

  always_comb begin
    rsp_o.prdata = '0;
    err          = 1'b0;
    case (offset)
      `SOC_PERIPH_CTRL_INFO_OFS: begin
        rsp_o.prdata = {16'(`SOC_PERIPH_NB_CORES), 16'(`SOC_PERIPH_NB_CLUSTERS)};
        err          = req_i.pwrite;
      end
      `SOC_PERIPH_CTRL_BOOTADDR_OFS: rsp_o.prdata = bootaddr_q;
      `SOC_PERIPH_CTRL_FETCH_EN_OFS: rsp_o.prdata = {31'b0, fetch_en_q};
      // In half is live, only the out half takes writes
      `SOC_PERIPH_CTRL_JTAG_OFS:     rsp_o.prdata = {16'b0, jtag_i, jtag_out_q};
      `SOC_PERIPH_CTRL_BOOTSEL_OFS: begin
        rsp_o.prdata = {30'b0, bootsel_i};
        err          = req_i.pwrite;
      end
      `SOC_PERIPH_CTRL_CLUSTER_OFS:  rsp_o.prdata = {31'b0, cluster_q};
      default:                       err = 1'b1;
    endcase
  end

  assign rsp_o.pready  = 1'b1;
  assign rsp_o.pslverr = access & err;

  assign bootaddr_o         = bootaddr_q;
  assign fetch_en_o         = fetch_en_q;
  assign jtag_o             = jtag_out_q;
  assign cluster_rstn_req_o = cluster_q;

  // Every setup phase is followed by a completing access phase
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i.psel && !req_i.penable) |=> (req_i.penable && rsp_o.pready))
    else $error("SoC control access did not complete after setup");

endmodule

//--- hw/soc_periph_bus_pkg.sv
// APB-side types shared by the peripheral block, its slaves and the testbench
`include "soc_periph_config.svh"

package soc_periph_bus_pkg;

  typedef logic [`SOC_PERIPH_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`SOC_PERIPH_DATA_WIDTH-1:0] data_t;

  // Request from the APB master
  typedef struct packed {
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    data_t pwdata;
  } apb_req_t;

  // Response from the slave, valid in the access cycle
  typedef struct packed {
    data_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

endpackage

//--- hw/soc_periph_config.svh
// Address map, register offsets, reset values and interrupt bit positions; include where needed
`ifndef SOC_PERIPH_CONFIG_SVH
`define SOC_PERIPH_CONFIG_SVH

// Bus widths
`define SOC_PERIPH_ADDR_WIDTH 32
`define SOC_PERIPH_DATA_WIDTH 32

// Values reported in the INFO register
`define SOC_PERIPH_NB_CORES    4
`define SOC_PERIPH_NB_CLUSTERS 0

// Peripheral regions
`define SOC_PERIPH_SOC_CTRL_BASE 32'h1A10_4000
`define SOC_PERIPH_TIMER_BASE    32'h1A10_B000
`define SOC_PERIPH_REGION_SIZE   32'h0000_1000

`define SOC_PERIPH_BOOTADDR_RST 32'h1A00_0080

// SoC control register offsets
`define SOC_PERIPH_CTRL_INFO_OFS     32'h0000_0000
`define SOC_PERIPH_CTRL_BOOTADDR_OFS 32'h0000_0004
`define SOC_PERIPH_CTRL_FETCH_EN_OFS 32'h0000_0008
`define SOC_PERIPH_CTRL_JTAG_OFS     32'h0000_000C
`define SOC_PERIPH_CTRL_BOOTSEL_OFS  32'h0000_0010
`define SOC_PERIPH_CTRL_CLUSTER_OFS  32'h0000_0014

// Timer register offsets
`define SOC_PERIPH_TMR_CFG_OFS   32'h0000_0000
`define SOC_PERIPH_TMR_COUNT_OFS 32'h0000_0004
`define SOC_PERIPH_TMR_CMP_OFS   32'h0000_0008

// Fabric controller interrupt map
`define SOC_PERIPH_IRQ_DMA_EVT   8
`define SOC_PERIPH_IRQ_DMA_IRQ   9
`define SOC_PERIPH_IRQ_TIMER_LO  10
`define SOC_PERIPH_IRQ_PF_EVT    12
`define SOC_PERIPH_IRQ_REF_EDGE  14

`endif

//--- hw/soc_periph_irq_pkg.sv
// Event-side types: interrupt vector, timer values and the side-band SoC inputs
`include "soc_periph_config.svh"

package soc_periph_irq_pkg;

  // Fabric controller interrupt lines, one bit per source
  typedef logic [31:0] irq_vec_t;

  // Timer count and compare value
  typedef logic [`SOC_PERIPH_DATA_WIDTH-1:0] tmr_cnt_t;

  // JTAG configuration byte, one each way
  typedef logic [7:0] jtag_reg_t;

  // Boot mode straps
  typedef logic [1:0] bootsel_t;

endpackage

//--- hw/soc_periph_top.sv
// Peripheral subsystem top: APB decode, SoC control, timer and fabric controller interrupts
`include "soc_periph_config.svh"
`timescale 1ns/1ps

module soc_periph_top
  import soc_periph_bus_pkg::*;
  import soc_periph_irq_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  apb_req_t  apb_req_i,
  output apb_rsp_t  apb_rsp_o,
  input  logic      slow_clk_i,
  input  jtag_reg_t soc_jtag_reg_i,
  output jtag_reg_t soc_jtag_reg_o,
  input  bootsel_t  bootsel_i,
  input  logic      fc_fetch_en_valid_i,
  input  logic      fc_fetch_en_i,
  output addr_t     fc_bootaddr_o,
  output logic      fc_fetchen_o,
  output logic      cluster_rstn_req_o,
  input  logic      dma_pe_evt_i,
  input  logic      dma_pe_irq_i,
  input  logic      pf_evt_i,
  output irq_vec_t  fc_interrupts_o
);

  apb_req_t ctrl_req;
  apb_req_t tmr_req;
  apb_rsp_t ctrl_rsp;
  apb_rsp_t tmr_rsp;
  logic     ref_rise;
  logic     ref_fall;
  logic     timer_irq;

  //////////////////////////////////////////////////
  // Bus decode and slaves
  //////////////////////////////////////////////////

  periph_apb_demux i_periph_apb_demux (
    .apb_req_i  ( apb_req_i ),
    .apb_rsp_o  ( apb_rsp_o ),
    .ctrl_req_o ( ctrl_req  ),
    .tmr_req_o  ( tmr_req   ),
    .ctrl_rsp_i ( ctrl_rsp  ),
    .tmr_rsp_i  ( tmr_rsp   )
  );

  soc_ctrl_regs i_soc_ctrl_regs (
    .clk_i              ( clk_i               ),
    .rst_ni             ( rst_ni              ),
    .req_i              ( ctrl_req            ),
    .rsp_o              ( ctrl_rsp            ),
    .jtag_i             ( soc_jtag_reg_i      ),
    .jtag_o             ( soc_jtag_reg_o      ),
    .bootsel_i          ( bootsel_i           ),
    .fetch_en_valid_i   ( fc_fetch_en_valid_i ),
    .fetch_en_i         ( fc_fetch_en_i       ),
    .bootaddr_o         ( fc_bootaddr_o       ),
    .fetch_en_o         ( fc_fetchen_o        ),
    .cluster_rstn_req_o ( cluster_rstn_req_o  )
  );

  ref_clk_edge_sync i_ref_clk_edge_sync (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .slow_clk_i ( slow_clk_i ),
    .rise_o     ( ref_rise   ),
    .fall_o     ( ref_fall   )
  );

  apb_timer_unit i_apb_timer_unit (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .req_i      ( tmr_req   ),
    .rsp_o      ( tmr_rsp   ),
    .ref_tick_i ( ref_rise  ),
    .irq_o      ( timer_irq )
  );

  //////////////////////////////////////////////////
  // Interrupt vector
  //////////////////////////////////////////////////

  // Unused lines, the timer high half among them, stay 0
  always_comb begin
    fc_interrupts_o                              = '0;
    fc_interrupts_o[`SOC_PERIPH_IRQ_DMA_EVT]     = dma_pe_evt_i;
    fc_interrupts_o[`SOC_PERIPH_IRQ_DMA_IRQ]     = dma_pe_irq_i;
    fc_interrupts_o[`SOC_PERIPH_IRQ_TIMER_LO]    = timer_irq;
    fc_interrupts_o[`SOC_PERIPH_IRQ_PF_EVT]      = pf_evt_i;
    fc_interrupts_o[`SOC_PERIPH_IRQ_REF_EDGE]    = ref_rise | ref_fall;
  end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f soc_periph_top.f --top-module tb_soc_periph_top

output=$(./obj_dir/Vtb_soc_periph_top) || true
echo "$output"

if echo "$output" | grep -qx "All tests passed"; then
  exit 0
fi
exit 1

//--- soc_periph_top.f
+incdir+hw
hw/soc_periph_bus_pkg.sv
hw/soc_periph_irq_pkg.sv
hw/periph_apb_demux.sv
hw/soc_ctrl_regs.sv
hw/ref_clk_edge_sync.sv
hw/apb_timer_unit.sv
hw/soc_periph_top.sv
testbench/soc_periph_checker.sv
testbench/tb_soc_periph_top.sv

//--- testbench/soc_periph_checker.sv
// Testbench checker: watches the DUT APB port, compares against expectations and keeps test counts
`timescale 1ns/1ps

module soc_periph_checker
  import soc_periph_bus_pkg::*;
(
  input logic     clk_i,
  input logic     rst_ni,
  input apb_req_t apb_req_i,
  input apb_rsp_t apb_rsp_i,
  input logic     chk_apb_i,
  input logic     chk_rdata_i,
  input data_t    exp_rdata_i,
  input logic     exp_err_i
);

  int errors = 0;
  int errors_mark = 0;
  int tests_run = 0;
  int tests_failed = 0;

  // Response is only meaningful in the completing access cycle
  always @(posedge clk_i) begin
    if (rst_ni && chk_apb_i && apb_req_i.psel && apb_req_i.penable && apb_rsp_i.pready) begin
      if (apb_rsp_i.pslverr !== exp_err_i) begin
        $display("MISMATCH at %0t: pslverr at 0x%08h is %b, expected %b",
                 $time, apb_req_i.paddr, apb_rsp_i.pslverr, exp_err_i);
        errors++;
      end
      if (chk_rdata_i && apb_rsp_i.prdata !== exp_rdata_i) begin
        $display("MISMATCH at %0t: prdata at 0x%08h is 0x%08h, expected 0x%08h",
                 $time, apb_req_i.paddr, apb_rsp_i.prdata, exp_rdata_i);
        errors++;
      end
    end
  end

  task automatic check_word(input string what, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic note_failure(input string what);
    $display("ERROR at %0t: %s", $time, what);
    errors++;
  endtask

  // One result line per finished test
  task automatic close_test(input int idx, input string name);
    tests_run++;
    if (errors != errors_mark) begin
      tests_failed++;
      $display("test %0d %s: FAIL", idx, name);
    end else begin
      $display("test %0d %s: PASS", idx, name);
    end
    errors_mark = errors;
  endtask

endmodule

//--- testbench/tb_soc_periph_top.sv
// Testbench top: clock, reset and a stimulus table driven into the peripheral subsystem
`include "soc_periph_config.svh"
`timescale 1ns/1ps

module tb_soc_periph_top
  import soc_periph_bus_pkg::*;
  import soc_periph_irq_pkg::*;
();

  localparam logic [2:0] OP_WR   = 3'd0;
  localparam logic [2:0] OP_RD   = 3'd1;
  localparam logic [2:0] OP_SIDE = 3'd2;
  localparam logic [2:0] OP_OUTS = 3'd3;
  localparam logic [2:0] OP_REF  = 3'd4;
  localparam logic [2:0] OP_TPER = 3'd5;
  localparam logic [2:0] OP_TCNT = 3'd6;

  localparam int    WAIT_LIMIT = 64;
  localparam int    TMR_BIT    = `SOC_PERIPH_IRQ_TIMER_LO;
  localparam int    REF_BIT    = `SOC_PERIPH_IRQ_REF_EDGE;
  localparam addr_t CTRL       = `SOC_PERIPH_SOC_CTRL_BASE;
  localparam addr_t TMR        = `SOC_PERIPH_TIMER_BASE;
  localparam addr_t BOOT_NEW   = 32'h1C00_8000;
  localparam data_t INFO_VAL   = data_t'((`SOC_PERIPH_NB_CORES << 16) | `SOC_PERIPH_NB_CLUSTERS);
  localparam data_t DMA_EVT    = data_t'(1) << `SOC_PERIPH_IRQ_DMA_EVT;
  localparam data_t DMA_IRQ    = data_t'(1) << `SOC_PERIPH_IRQ_DMA_IRQ;
  localparam data_t PF_EVT     = data_t'(1) << `SOC_PERIPH_IRQ_PF_EVT;

  typedef struct packed {
    logic [2:0] op;
    addr_t      addr;
    data_t      wdata;
    data_t      exp;
    logic       exp_err;
  } entry_t;

  logic      clk_i;
  logic      rst_ni;
  apb_req_t  apb_req;
  apb_rsp_t  apb_rsp;
  logic      slow_clk;
  jtag_reg_t jtag_in;
  jtag_reg_t jtag_out;
  bootsel_t  bootsel;
  logic      fetch_valid;
  logic      fetch_en;
  addr_t     bootaddr;
  logic      fetchen;
  logic      cluster_req;
  logic      dma_evt;
  logic      dma_irq;
  logic      pf_evt;
  irq_vec_t  irqs;
  logic      chk_apb;
  logic      chk_rdata;
  data_t     exp_rdata;
  logic      exp_err;
  entry_t    tests [$];

  soc_periph_top i_soc_periph_top (
    .clk_i               ( clk_i       ),
    .rst_ni              ( rst_ni      ),
    .apb_req_i           ( apb_req     ),
    .apb_rsp_o           ( apb_rsp     ),
    .slow_clk_i          ( slow_clk    ),
    .soc_jtag_reg_i      ( jtag_in     ),
    .soc_jtag_reg_o      ( jtag_out    ),
    .bootsel_i           ( bootsel     ),
    .fc_fetch_en_valid_i ( fetch_valid ),
    .fc_fetch_en_i       ( fetch_en    ),
    .fc_bootaddr_o       ( bootaddr    ),
    .fc_fetchen_o        ( fetchen     ),
    .cluster_rstn_req_o  ( cluster_req ),
    .dma_pe_evt_i        ( dma_evt     ),
    .dma_pe_irq_i        ( dma_irq     ),
    .pf_evt_i            ( pf_evt      ),
    .fc_interrupts_o     ( irqs        )
  );

  soc_periph_checker i_soc_periph_checker (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .apb_req_i   ( apb_req   ),
    .apb_rsp_i   ( apb_rsp   ),
    .chk_apb_i   ( chk_apb   ),
    .chk_rdata_i ( chk_rdata ),
    .exp_rdata_i ( exp_rdata ),
    .exp_err_i   ( exp_err   )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////

  function automatic void add_entry(input logic [2:0] op, input addr_t addr, input data_t wdata,
                                    input data_t exp, input logic err);
    tests.push_back('{op, addr, wdata, exp, err});
  endfunction

  function automatic string op_name(input logic [2:0] op);
    case (op)
      OP_WR:   return "apb write";
      OP_RD:   return "apb read";
      OP_SIDE: return "side inputs";
      OP_OUTS: return "outputs";
      OP_REF:  return "ref edge";
      OP_TPER: return "timer period";
      default: return "timer ref count";
    endcase
  endfunction

  // Side inputs in wdata: [7:0] jtag in, [9:8] bootsel, [10] fetch valid,
  // [11] fetch enable, [12] dma event, [13] dma irq, [14] prefetch event
  function automatic void build_table();
    add_entry(OP_RD,   CTRL + `SOC_PERIPH_CTRL_INFO_OFS, '0, INFO_VAL, 1'b0);
    add_entry(OP_RD,   CTRL + `SOC_PERIPH_CTRL_BOOTADDR_OFS, '0, `SOC_PERIPH_BOOTADDR_RST, 1'b0);
    add_entry(OP_OUTS, `SOC_PERIPH_BOOTADDR_RST, '0, 32'h0, 1'b0);
    add_entry(OP_SIDE, '0, 32'h0, 32'h0, 1'b0);
    // Read back after write, outputs one cycle after the access
    add_entry(OP_WR,   CTRL + `SOC_PERIPH_CTRL_BOOTADDR_OFS, BOOT_NEW, '0, 1'b0);
    add_entry(OP_OUTS, BOOT_NEW, '0, 32'h0, 1'b0);
    add_entry(OP_RD,   CTRL + `SOC_PERIPH_CTRL_BOOTADDR_OFS, '0, BOOT_NEW, 1'b0);
    add_entry(OP_WR,   CTRL + `SOC_PERIPH_CTRL_FETCH_EN_OFS, 32'h1, '0, 1'b0);
    add_entry(OP_OUTS, BOOT_NEW, '0, 32'h100, 1'b0);
    add_entry(OP_RD,   CTRL + `SOC_PERIPH_CTRL_FETCH_EN_OFS, '0, 32'h1, 1'b0);
    add_entry(OP_WR,   CTRL + `SOC_PERIPH_CTRL_JTAG_OFS, 32'hFFFF_FFA5, '0, 1'b0);
    add_entry(OP_OUTS, BOOT_NEW, '0, 32'h1A5, 1'b0);
    add_entry(OP_RD,   CTRL + `SOC_PERIPH_CTRL_JTAG_OFS, '0, 32'h0000_00A5, 1'b0);
    add_entry(OP_WR,   CTRL + `SOC_PERIPH_CTRL_CLUSTER_OFS, 32'h1, '0, 1'b0);
    add_entry(OP_OUTS, BOOT_NEW, '0, 32'h3A5, 1'b0);
    add_entry(OP_RD,   CTRL + `SOC_PERIPH_CTRL_CLUSTER_OFS, '0, 32'h1, 1'b0);
    // Error responses, then a normal access
    add_entry(OP_RD,   32'h1A20_0000, '0, 32'h0, 1'b1);
    add_entry(OP_WR,   CTRL + `SOC_PERIPH_CTRL_INFO_OFS, 32'h1234, '0, 1'b1);
    add_entry(OP_WR,   CTRL + `SOC_PERIPH_CTRL_BOOTSEL_OFS, 32'h3, '0, 1'b1);
    add_entry(OP_RD,   TMR + 32'h0C, '0, 32'h0, 1'b1);
    add_entry(OP_RD,   CTRL + `SOC_PERIPH_CTRL_INFO_OFS, '0, INFO_VAL, 1'b0);
    // Pad-side fetch enable, live JTAG and boot select
    add_entry(OP_SIDE, '0, 32'h0000_063C, 32'h0, 1'b0);
    add_entry(OP_RD,   CTRL + `SOC_PERIPH_CTRL_FETCH_EN_OFS, '0, 32'h0, 1'b0);
    add_entry(OP_RD,   CTRL + `SOC_PERIPH_CTRL_JTAG_OFS, '0, 32'h0000_3CA5, 1'b0);
    add_entry(OP_RD,   CTRL + `SOC_PERIPH_CTRL_BOOTSEL_OFS, '0, 32'h2, 1'b0);
    add_entry(OP_OUTS, BOOT_NEW, '0, 32'h2A5, 1'b0);
    add_entry(OP_SIDE, '0, 32'h0000_0E3C, 32'h0, 1'b0);
    add_entry(OP_RD,   CTRL + `SOC_PERIPH_CTRL_FETCH_EN_OFS, '0, 32'h1, 1'b0);
    // Pass-through interrupt lines
    add_entry(OP_SIDE, '0, 32'h0000_123C, DMA_EVT, 1'b0);
    add_entry(OP_SIDE, '0, 32'h0000_223C, DMA_IRQ, 1'b0);
    add_entry(OP_SIDE, '0, 32'h0000_423C, PF_EVT, 1'b0);
    add_entry(OP_SIDE, '0, 32'h0000_723C, DMA_EVT | DMA_IRQ | PF_EVT, 1'b0);
    add_entry(OP_SIDE, '0, 32'h0000_023C, 32'h0, 1'b0);
    // Timer on clk_i, period is CMP+1
    add_entry(OP_WR,   TMR + `SOC_PERIPH_TMR_CMP_OFS, 32'd5, '0, 1'b0);
    add_entry(OP_WR,   TMR + `SOC_PERIPH_TMR_COUNT_OFS, 32'd0, '0, 1'b0);
    add_entry(OP_WR,   TMR + `SOC_PERIPH_TMR_CFG_OFS, 32'h1, '0, 1'b0);
    add_entry(OP_TPER, '0, '0, 32'd6, 1'b0);
    add_entry(OP_RD,   TMR + `SOC_PERIPH_TMR_CMP_OFS, '0, 32'd5, 1'b0);
    add_entry(OP_WR,   TMR + `SOC_PERIPH_TMR_CFG_OFS, 32'h0, '0, 1'b0);
    // Timer on ref rises, 6 periods with CMP 1 give 3 interrupts
    add_entry(OP_WR,   TMR + `SOC_PERIPH_TMR_CMP_OFS, 32'd1, '0, 1'b0);
    add_entry(OP_WR,   TMR + `SOC_PERIPH_TMR_COUNT_OFS, 32'd0, '0, 1'b0);
    add_entry(OP_WR,   TMR + `SOC_PERIPH_TMR_CFG_OFS, 32'h3, '0, 1'b0);
    add_entry(OP_RD,   TMR + `SOC_PERIPH_TMR_CFG_OFS, '0, 32'h3, 1'b0);
    add_entry(OP_TCNT, 32'd6, '0, 32'd3, 1'b0);
    add_entry(OP_WR,   TMR + `SOC_PERIPH_TMR_CFG_OFS, 32'h0, '0, 1'b0);
    // One edge pulse per ref toggle
    add_entry(OP_REF,  '0, '0, 32'd1, 1'b0);
    add_entry(OP_REF,  '0, '0, 32'd1, 1'b0);
  endfunction

  //////////////////////////////////////////////////
  // Drivers and monitors
  //////////////////////////////////////////////////

  task automatic apb_xfer(input logic write, input addr_t addr, input data_t wdata,
                          input data_t exp, input logic err);
    logic ready;
    int   n;
    ready = 1'b0;
    @(posedge clk_i);
    apb_req   <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    chk_apb   <= 1'b1;
    chk_rdata <= ~write;
    exp_rdata <= exp;
    exp_err   <= err;
    @(posedge clk_i);
    apb_req.penable <= 1'b1;
    for (n = 0; n < WAIT_LIMIT && !ready; n++) begin
      @(negedge clk_i);
      ready = apb_rsp.pready;
      @(posedge clk_i);
    end
    apb_req <= '0;
    chk_apb <= 1'b0;
    @(negedge clk_i);
    if (!ready) begin
      i_soc_periph_checker.note_failure($sformatf("APB transfer to 0x%08h timed out", addr));
    end
  endtask

  task automatic drive_side(input data_t f, input data_t exp);
    @(posedge clk_i);
    jtag_in     <= f[7:0];
    bootsel     <= f[9:8];
    fetch_valid <= f[10];
    fetch_en    <= f[11];
    dma_evt     <= f[12];
    dma_irq     <= f[13];
    pf_evt      <= f[14];
    @(negedge clk_i);
    i_soc_periph_checker.check_word("fc_interrupts_o", irqs, exp);
    // Fetch-enable valid is a one-cycle strobe
    @(posedge clk_i);
    fetch_valid <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic wait_irq(input int idx, output logic seen, output int cycles);
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < WAIT_LIMIT) begin
      @(negedge clk_i);
      cycles++;
      seen = irqs[idx];
    end
  endtask

  task automatic count_irq(input int idx, input int window, output int count);
    count = 0;
    repeat (window) begin
      @(negedge clk_i);
      if (irqs[idx]) begin
        count++;
      end
    end
  endtask

  task automatic count_ref_ticks(input int periods, input data_t exp);
    int pulses;
    int got;
    pulses = 0;
    // Half a ref period is 4 clk_i cycles
    repeat (2 * periods) begin
      @(posedge clk_i);
      slow_clk <= ~slow_clk;
      count_irq(TMR_BIT, 4, got);
      pulses += got;
    end
    count_irq(TMR_BIT, 8, got);
    pulses += got;
    i_soc_periph_checker.check_word("timer interrupts on ref source", data_t'(pulses), exp);
  endtask

  task automatic run_entry(input entry_t e);
    logic seen;
    int   cycles;
    int   extra;
    case (e.op)
      OP_WR:   apb_xfer(1'b1, e.addr, e.wdata, '0, e.exp_err);
      OP_RD:   apb_xfer(1'b0, e.addr, '0, e.exp, e.exp_err);
      OP_SIDE: drive_side(e.wdata, e.exp);
      OP_OUTS: begin
        i_soc_periph_checker.check_word("fc_bootaddr_o", bootaddr, e.addr);
        i_soc_periph_checker.check_word("cluster, fetch and jtag outputs",
                                        {22'b0, cluster_req, fetchen, jtag_out}, e.exp);
      end
      OP_REF: begin
        @(posedge clk_i);
        slow_clk <= ~slow_clk;
        wait_irq(REF_BIT, seen, cycles);
        if (!seen) begin
          i_soc_periph_checker.note_failure("no ref edge pulse after a ref clock toggle");
        end else begin
          count_irq(REF_BIT, 8, extra);
          i_soc_periph_checker.check_word("ref edge pulses", data_t'(extra + 1), e.exp);
        end
      end
      OP_TPER: begin
        wait_irq(TMR_BIT, seen, cycles);
        if (seen) begin
          wait_irq(TMR_BIT, seen, cycles);
        end
        if (!seen) begin
          i_soc_periph_checker.note_failure("timer interrupt did not pulse twice");
        end else begin
          i_soc_periph_checker.check_word("timer interrupt period", data_t'(cycles), e.exp);
        end
      end
      default: count_ref_ticks(int'(e.addr), e.exp);
    endcase
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int idx;
    rst_ni      = 1'b0;
    apb_req     = '0;
    slow_clk    = 1'b0;
    jtag_in     = '0;
    bootsel     = '0;
    fetch_valid = 1'b0;
    fetch_en    = 1'b0;
    dma_evt     = 1'b0;
    dma_irq     = 1'b0;
    pf_evt      = 1'b0;
    chk_apb     = 1'b0;
    chk_rdata   = 1'b0;
    exp_rdata   = '0;
    exp_err     = 1'b0;
    build_table();
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    for (idx = 0; idx < tests.size(); idx++) begin
      run_entry(tests[idx]);
      i_soc_periph_checker.close_test(idx, op_name(tests[idx].op));
    end
    $display("Tests run: %0d, failed: %0d",
             i_soc_periph_checker.tests_run, i_soc_periph_checker.tests_failed);
    if (i_soc_periph_checker.tests_failed == 0 &&
        i_soc_periph_checker.tests_run == tests.size()) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
